//--- verilog.f
+incdir+verilog
verilog/spcAluPkg.sv
verilog/spcFlagsPkg.sv
verilog/spcAluBeatIf.sv
verilog/spcAddSub.sv
verilog/spcBcdAdjust.sv
verilog/spcAlu.sv
verilog/spcOpDecode.sv
verilog/spcAluSequencer.sv
verilog/spcAluUnit.sv
dv/spcAluUnit_chk.sv
dv/spcAluUnitTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= spcAluUnitTb
FILELIST  ?= verilog.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf $(OBJDIR)

//--- dv/spcAluUnitTb.sv
`include "spcAlu_defs.svh"
`default_nettype none

module spcAluUnitTb;
    timeunit 1ns;
    timeprecision 100ps;

    import spcAluPkg::*;
    import spcFlagsPkg::*;

    typedef struct {
        string       name;
        SpcOpcode    op;
        logic [15:0] l;
        logic [15:0] r;
        logic [15:0] expRes;
        SpcFlags     expFlags;
    } TestEntry;

    logic        CLK = 1'b0;
    logic        RST_N;
    logic        reqValid = 1'b0;
    SpcOpcode    reqOp = OP_OR;
    logic [15:0] reqL = 16'h0000;
    logic [15:0] reqR = 16'h0000;
    logic        reqCredit;
    logic        rspCredit = 1'b0;
    logic        rspValid;
    logic [15:0] rspResult;
    SpcFlags     rspFlags;

    TestEntry    tbl[$];
    SpcFlags     modelStatus;
    logic [15:0] lastRes;
    logic [31:0] rngState = 32'd67;
    int          nMain;
    int          sendLimit = 0;
    int          reqSent = 0;
    int          reqReturned = 0;
    int          rspCount = 0;
    int          rspGiven = 0;
    logic        holdCredits = 1'b0;
    int          cycles = 0;
    int          cycleLimit = 1000000;
    int          resultErrors = 0;
    int          flagErrors = 0;
    int          extraErrors = 0;
    int          stallErrors = 0;

    spcAluUnit spcAluUnit_inst (
        .CLK       (CLK),
        .RST_N     (RST_N),
        .reqValid  (reqValid),
        .reqOp     (reqOp),
        .reqL      (reqL),
        .reqR      (reqR),
        .reqCredit (reqCredit),
        .rspCredit (rspCredit),
        .rspValid  (rspValid),
        .rspResult (rspResult),
        .rspFlags  (rspFlags)
    );

    always #4 CLK = ~CLK;

    function automatic logic [7:0] randByte();
        rngState = rngState * 32'd1103515245 + 32'd12345;
        return rngState[23:16];
    endfunction

    function automatic logic [7:0] bcdByte();
        logic [7:0] hi;
        logic [7:0] lo;
        hi = randByte() % 8'd10;
        lo = randByte() % 8'd10;
        return {hi[3:0], lo[3:0]};
    endfunction

    function automatic SpcOpcode unaryOp(input logic [7:0] sel);
        case (sel % 8'd6)
            8'd0:    return OP_ASL;
            8'd1:    return OP_ROL;
            8'd2:    return OP_LSR;
            8'd3:    return OP_ROR;
            8'd4:    return OP_INC;
            default: return OP_DEC;
        endcase
    endfunction

    // Byte add with carry in packed as {h, v, c, sum}
    function automatic logic [10:0] addBits(input logic [7:0] a, input logic [7:0] b,
                                            input logic ci);
        int sum;
        int half;
        int sgn;
        sum = int'(a) + int'(b) + int'(ci);
        half = int'(a[3:0]) + int'(b[3:0]) + int'(ci);
        sgn = int'($signed(a)) + int'($signed(b)) + int'(ci);
        return {half > 15, (sgn > 127) || (sgn < -128), sum > 255, sum[7:0]};
    endfunction

    task automatic modelOp(input SpcOpcode op, input logic [15:0] l, input logic [15:0] r,
                           output logic [15:0] res);
        logic [7:0]  y;
        logic [7:0]  adj;
        logic [10:0] lo;
        logic [10:0] hi;
        logic        sub;
        y = 8'h00;
        adj = 8'h00;
        sub = (op == OP_SUBW);
        case (op)
            OP_OR:    y = l[7:0] | r[7:0];
            OP_AND:   y = l[7:0] & r[7:0];
            OP_EOR:   y = l[7:0] ^ r[7:0];
            OP_MOV:   y = r[7:0];
            OP_TCLR1: y = r[7:0] & ~l[7:0];
            OP_TSET1: y = r[7:0] | l[7:0];
            OP_XCN:   y = {r[3:0], r[7:4]};
            OP_ASL: begin
                y = {r[6:0], 1'b0};
                modelStatus.c = r[7];
            end
            OP_ROL: begin
                y = {r[6:0], modelStatus.c};
                modelStatus.c = r[7];
            end
            OP_LSR: begin
                y = {1'b0, r[7:1]};
                modelStatus.c = r[0];
            end
            OP_ROR: begin
                y = {modelStatus.c, r[7:1]};
                modelStatus.c = r[0];
            end
            OP_INC:   y = l[7:0] + 8'd1;
            OP_DEC:   y = l[7:0] - 8'd1;
            OP_ADC, OP_SBC: begin
                lo = addBits(l[7:0], (op == OP_ADC) ? r[7:0] : ~r[7:0], modelStatus.c);
                y = lo[7:0];
                modelStatus.h = lo[10];
                modelStatus.v = lo[9];
                modelStatus.c = lo[8];
            end
            OP_DAA: begin
                if (modelStatus.c || l[7:0] > 8'h99) begin
                    adj = 8'h60;
                    modelStatus.c = 1'b1;
                end
                if (modelStatus.h || l[3:0] > 4'h9) begin
                    adj = adj + 8'h06;
                end
                y = l[7:0] + adj;
            end
            OP_DAS: begin
                if (!modelStatus.c || l[7:0] > 8'h99) begin
                    adj = 8'h60;
                    modelStatus.c = 1'b0;
                end
                if (!modelStatus.h || l[3:0] > 4'h9) begin
                    adj = adj + 8'h06;
                end
                y = l[7:0] - adj;
            end
            default: begin
                // Word ops take the low byte then the high byte
                lo = addBits(l[7:0], sub ? ~r[7:0] : r[7:0], sub);
                hi = addBits(l[15:8], sub ? ~r[15:8] : r[15:8], lo[8]);
                modelStatus.h = hi[10];
                modelStatus.v = hi[9];
                modelStatus.c = hi[8];
            end
        endcase
        if (op == OP_ADDW || op == OP_SUBW) begin
            res = {hi[7:0], lo[7:0]};
            modelStatus.s = res[15];
        end else begin
            res = {8'h00, y};
            modelStatus.s = y[7];
        end
        modelStatus.z = (res == 16'h0000);
    endtask

    task automatic addEntry(input string name, input SpcOpcode op, input logic [15:0] l,
                            input logic [15:0] r);
        TestEntry    e;
        logic [15:0] res;
        modelOp(op, l, r, res);
        e.name = name;
        e.op = op;
        e.l = l;
        e.r = r;
        e.expRes = res;
        e.expFlags = modelStatus;
        lastRes = res;
        tbl.push_back(e);
    endtask

    task automatic buildTable();
        modelStatus = '0;
        // Sets C, V and H so logic ops can show them unchanged
        addEntry("adcPrime", OP_ADC, 16'h0088, 16'h0088);
        addEntry("or", OP_OR, 16'h000F, 16'h00A0);
        addEntry("andZero", OP_AND, 16'h00F0, 16'h000F);
        addEntry("eor", OP_EOR, 16'h00FF, 16'h005A);
        addEntry("mov", OP_MOV, 16'h0000, 16'h0080);
        addEntry("tclr1", OP_TCLR1, 16'h000F, 16'h003C);
        addEntry("tset1", OP_TSET1, 16'h0081, 16'h0010);
        addEntry("xcn", OP_XCN, 16'h0000, 16'h005A);
        addEntry("incWrap", OP_INC, 16'h00FF, 16'h0000);
        addEntry("decWrap", OP_DEC, 16'h0000, 16'h0000);
        for (int i = 0; i < 12; i++) begin
            addEntry($sformatf("unary%0d", i), unaryOp(randByte()),
                     {8'h00, randByte()}, {8'h00, randByte()});
        end
        addEntry("adcCarryOut", OP_ADC, 16'h00FF, 16'h0001);
        addEntry("adcCarryIn", OP_ADC, 16'h0010, 16'h0020);
        addEntry("adcOverflow", OP_ADC, 16'h007F, 16'h0001);
        addEntry("sbcBorrow", OP_SBC, 16'h0000, 16'h0001);
        addEntry("sbcChain", OP_SBC, 16'h0050, 16'h0010);
        for (int i = 0; i < 6; i++) begin
            addEntry($sformatf("carryChain%0d", i), (i % 2 == 0) ? OP_ADC : OP_SBC,
                     {8'h00, randByte()}, {8'h00, randByte()});
        end
        addEntry("clrC", OP_ASL, 16'h0000, 16'h0000);
        addEntry("adcBcd", OP_ADC, 16'h0015, 16'h0027);
        addEntry("daa", OP_DAA, lastRes, 16'h0000);
        for (int i = 0; i < 3; i++) begin
            addEntry($sformatf("clrC%0d", i), OP_ASL, 16'h0000, 16'h0000);
            addEntry($sformatf("adcBcd%0d", i), OP_ADC, {8'h00, bcdByte()}, {8'h00, bcdByte()});
            addEntry($sformatf("daa%0d", i), OP_DAA, lastRes, 16'h0000);
            addEntry($sformatf("setC%0d", i), OP_LSR, 16'h0000, 16'h0001);
            addEntry($sformatf("sbcBcd%0d", i), OP_SBC, {8'h00, bcdByte()}, {8'h00, bcdByte()});
            addEntry($sformatf("das%0d", i), OP_DAS, lastRes, 16'h0000);
        end
        addEntry("addw", OP_ADDW, 16'h1234, 16'h0FCC);
        addEntry("addwZero", OP_ADDW, 16'h8000, 16'h8000);
        addEntry("addwLowZero", OP_ADDW, 16'h00FF, 16'h0001);
        // High byte wraps to zero while the low byte does not
        addEntry("addwWrap", OP_ADDW, 16'h0101, 16'hFF00);
        addEntry("subw", OP_SUBW, 16'h1000, 16'h0001);
        addEntry("subwZero", OP_SUBW, 16'h1234, 16'h1234);
        addEntry("subwBorrow", OP_SUBW, 16'h0000, 16'h0001);
        for (int i = 0; i < 4; i++) begin
            addEntry($sformatf("addwRand%0d", i), OP_ADDW, {randByte(), randByte()},
                     {randByte(), randByte()});
            addEntry($sformatf("subwRand%0d", i), OP_SUBW, {randByte(), randByte()},
                     {randByte(), randByte()});
        end
        nMain = tbl.size();
        // Sent while response credits are withheld
        for (int i = 0; i < 8; i++) begin
            addEntry($sformatf("stall%0d", i), (i % 2 == 0) ? OP_ADC : OP_EOR,
                     {8'h00, randByte()}, {8'h00, randByte()});
        end
    endtask

    task automatic checkResult(input string name, input logic [15:0] exp,
                               input logic [15:0] act);
        if (act !== exp) begin
            $display("[FAIL] %s: result expected %h, actual %h", name, exp, act);
            resultErrors = resultErrors + 1;
        end
    endtask

    task automatic checkFlags(input string name, input SpcFlags exp, input SpcFlags act);
        if (act !== exp) begin
            $display("[FAIL] %s: flags cvszh expected %b, actual %b", name, exp, act);
            flagErrors = flagErrors + 1;
        end
    endtask

    task automatic checkCount(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("[FAIL] %s: expected %0d, actual %0d", name, exp, act);
            stallErrors = stallErrors + 1;
        end
    endtask

    // Request sender limited by the client's request credits
    always @(posedge CLK) begin
        if (RST_N && reqSent < sendLimit && reqSent - reqReturned < `SPC_QUEUE_DEPTH) begin
            reqValid <= 1'b1;
            reqOp <= tbl[reqSent].op;
            reqL <= tbl[reqSent].l;
            reqR <= tbl[reqSent].r;
            reqSent = reqSent + 1;
        end else begin
            reqValid <= 1'b0;
        end
    end

    // One response credit back per response consumed
    always @(posedge CLK) begin
        if (!holdCredits && rspGiven < rspCount) begin
            rspCredit <= 1'b1;
            rspGiven = rspGiven + 1;
        end else begin
            rspCredit <= 1'b0;
        end
    end

    always @(negedge CLK) begin
        if (RST_N) begin
            if (reqCredit) begin
                reqReturned = reqReturned + 1;
            end
            if (rspValid) begin
                if (rspCount < tbl.size()) begin
                    checkResult(tbl[rspCount].name, tbl[rspCount].expRes, rspResult);
                    checkFlags(tbl[rspCount].name, tbl[rspCount].expFlags, rspFlags);
                end else begin
                    $display("A response arrived with no request left to match it");
                    extraErrors = extraErrors + 1;
                end
                rspCount = rspCount + 1;
            end
        end
    end

    always @(posedge CLK) begin
        cycles = cycles + 1;
        if (cycles > cycleLimit) begin
            $display("Timeout: responses still missing after %0d cycles", cycleLimit);
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin
        RST_N = 1'b0;
        buildTable();
        cycleLimit = 40 * tbl.size() + 10;
        repeat (10) @(posedge CLK);
        RST_N <= 1'b1;
        @(negedge CLK);
        sendLimit = nMain;
        while (rspCount < nMain) begin
            @(negedge CLK);
        end
        repeat (3) @(negedge CLK);
        holdCredits = 1'b1;
        sendLimit = tbl.size();
        repeat (30) @(negedge CLK);
        checkCount("stallResponses", nMain + `SPC_RSP_CREDITS, rspCount);
        checkCount("stallReqCredits", nMain + `SPC_RSP_CREDITS, reqReturned);
        checkCount("stallRequestsSent", nMain + `SPC_RSP_CREDITS + `SPC_QUEUE_DEPTH, reqSent);
        holdCredits = 1'b0;
        while (rspCount < tbl.size()) begin
            @(negedge CLK);
        end
        repeat (5) @(negedge CLK);
        $display("Errors: result %0d, flags %0d, unmatched %0d, stall %0d",
                 resultErrors, flagErrors, extraErrors, stallErrors);
        if (resultErrors + flagErrors + extraErrors + stallErrors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end
endmodule

`default_nettype wire

//--- dv/spcAluUnit_chk.sv
`include "spcAlu_defs.svh"
`default_nettype none

module spcAluUnitChk (
    input logic CLK,
    input logic RST_N,
    input logic reqValid,
    input logic reqCredit,
    input logic rspValid,
    input logic rspCredit
);
    timeunit 1ns;
    timeprecision 100ps;

    int queueUsed;
    int rspOutstanding;

    // Client-side view of queue fill and unreturned responses
    always_ff @(posedge CLK) begin
        if (!RST_N) begin
            queueUsed <= 0;
            rspOutstanding <= 0;
        end else begin
            queueUsed <= queueUsed + (reqValid ? 1 : 0) - (reqCredit ? 1 : 0);
            rspOutstanding <= rspOutstanding + (rspValid ? 1 : 0) - (rspCredit ? 1 : 0);
        end
    end

    resetQuiet: assert property (@(posedge CLK) !RST_N |=> (!rspValid && !reqCredit))
        else $error("rspValid or reqCredit high in the cycle after reset");

    rspWithinCredit: assert property (@(posedge CLK) disable iff (!RST_N)
        rspOutstanding + (rspValid ? 1 : 0) <= `SPC_RSP_CREDITS)
        else $error("More responses outstanding than response credits");

    creditNeedsEntry: assert property (@(posedge CLK) disable iff (!RST_N)
        reqCredit |-> queueUsed > 0)
        else $error("reqCredit pulsed with the request queue empty");
endmodule

bind spcAluUnit spcAluUnitChk creditChk (
    .CLK       (CLK),
    .RST_N     (RST_N),
    .reqValid  (reqValid),
    .reqCredit (reqCredit),
    .rspValid  (rspValid),
    .rspCredit (rspCredit)
);

`default_nettype wire

//--- verilog/spcAluUnit.sv
`default_nettype none

module spcAluUnit (
    input  logic                 CLK,
    input  logic                 RST_N,
    input  logic                 reqValid,
    input  spcAluPkg::SpcOpcode  reqOp,
    input  logic [15:0]          reqL,
    input  logic [15:0]          reqR,
    output logic                 reqCredit,
    input  logic                 rspCredit,
    output logic                 rspValid,
    output logic [15:0]          rspResult,
    output spcFlagsPkg::SpcFlags rspFlags
);
    import spcAluPkg::*;

    SpcOpcode  decOp;
    logic      decHighBeat;
    SpcAluCtrl decCtrl;
    logic      decTwoBeats;

    spcAluBeatIf beatIf ();

    spcAluSequencer sequencer (
        .CLK         (CLK),
        .RST_N       (RST_N),
        .reqValid    (reqValid),
        .reqOp       (reqOp),
        .reqL        (reqL),
        .reqR        (reqR),
        .reqCredit   (reqCredit),
        .rspCredit   (rspCredit),
        .rspValid    (rspValid),
        .rspResult   (rspResult),
        .rspFlags    (rspFlags),
        .decOp       (decOp),
        .decHighBeat (decHighBeat),
        .decCtrl     (decCtrl),
        .decTwoBeats (decTwoBeats),
        .beat        (beatIf.seq)
    );

    spcOpDecode decoder (
        .op       (decOp),
        .highBeat (decHighBeat),
        .ctrl     (decCtrl),
        .twoBeats (decTwoBeats)
    );

    spcAlu alu (
        .CLK   (CLK),
        .RST_N (RST_N),
        .beat  (beatIf.alu)
    );
endmodule

`default_nettype wire

//--- verilog/spcAluSequencer.sv
`include "spcAlu_defs.svh"
`default_nettype none

module spcAluSequencer (
    input  logic                 CLK,
    input  logic                 RST_N,
    input  logic                 reqValid,
    input  spcAluPkg::SpcOpcode  reqOp,
    input  logic [15:0]          reqL,
    input  logic [15:0]          reqR,
    output logic                 reqCredit,
    input  logic                 rspCredit,
    output logic                 rspValid,
    output logic [15:0]          rspResult,
    output spcFlagsPkg::SpcFlags rspFlags,
    output spcAluPkg::SpcOpcode  decOp,
    output logic                 decHighBeat,
    input  spcAluPkg::SpcAluCtrl decCtrl,
    input  logic                 decTwoBeats,
    spcAluBeatIf.seq             beat
);
    import spcAluPkg::*;
    import spcFlagsPkg::*;

    localparam int queueDepth = `SPC_QUEUE_DEPTH;
    localparam int ptrW = $clog2(queueDepth);
    localparam int cntW = $clog2(queueDepth + 1);
    localparam int credW = $clog2(`SPC_RSP_CREDITS + 1);

    typedef enum logic [1:0] {
        IDLE,
        LOW,
        HIGH
    } BeatState;

    SpcOpcode         qOp [queueDepth];
    logic [15:0]      qL [queueDepth];
    logic [15:0]      qR [queueDepth];
    logic [ptrW-1:0]  wrPtr;
    logic [ptrW-1:0]  rdPtr;
    logic [cntW-1:0]  qCount;
    logic [credW-1:0] rspCredCnt;
    BeatState         stateQ;
    BeatState         beatNow;
    SpcFlags          status;
    logic [7:0]       resLo;
    logic             finalBeat;

    // A new op starts only with a response credit in hand
    always_comb begin
        if (stateQ == HIGH) begin
            beatNow = HIGH;
        end else if (qCount != '0 && rspCredCnt != '0) begin
            beatNow = LOW;
        end else begin
            beatNow = IDLE;
        end
    end

    assign finalBeat = (beatNow == HIGH) || (beatNow == LOW && !decTwoBeats);
    assign reqCredit = finalBeat;

    assign decOp = qOp[rdPtr];
    assign decHighBeat = (beatNow == HIGH);

    assign beat.en = (beatNow != IDLE);
    assign beat.ctrl = decCtrl;
    assign beat.l = decHighBeat ? qL[rdPtr][15:8] : qL[rdPtr][7:0];
    assign beat.r = decHighBeat ? qR[rdPtr][15:8] : qR[rdPtr][7:0];
    assign beat.w16 = decHighBeat;
    assign beat.flagsIn = status;

    always_ff @(posedge CLK) begin
        if (!RST_N) begin
            stateQ <= IDLE;
            wrPtr <= '0;
            rdPtr <= '0;
            qCount <= '0;
            rspCredCnt <= credW'(`SPC_RSP_CREDITS);
            status <= '0;
            rspValid <= 1'b0;
        end else begin
            stateQ <= (beatNow == LOW && decTwoBeats) ? HIGH : IDLE;
            if (reqValid) begin
                wrPtr <= (wrPtr == ptrW'(queueDepth - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (finalBeat) begin
                rdPtr <= (rdPtr == ptrW'(queueDepth - 1)) ? '0 : rdPtr + 1'b1;
            end
            qCount <= qCount + cntW'(reqValid) - cntW'(finalBeat);
            // Credit taken at op start
            rspCredCnt <= rspCredCnt + credW'(rspCredit) - credW'(beatNow == LOW);
            if (beat.en) begin
                status <= beat.flagsOut;
            end
            rspValid <= finalBeat;
        end
    end

    always_ff @(posedge CLK) begin
        if (reqValid) begin
            qOp[wrPtr] <= reqOp;
            qL[wrPtr] <= reqL;
            qR[wrPtr] <= reqR;
        end
        if (beatNow == LOW) begin
            resLo <= beat.res;
        end
        if (finalBeat) begin
            rspResult <= decHighBeat ? {beat.res, resLo} : {8'h00, beat.res};
            rspFlags <= beat.flagsOut;
        end
    end
endmodule

`default_nettype wire

//--- verilog/spcOpDecode.sv
`default_nettype none

module spcOpDecode (
    input  spcAluPkg::SpcOpcode  op,
    input  logic                 highBeat,
    output spcAluPkg::SpcAluCtrl ctrl,
    output logic                 twoBeats
);
    import spcAluPkg::*;

    // Unary ops on L: INC, DEC, DAA, DAS. Shifts, MOV and XCN work on R
    always_comb begin
        ctrl.fstOp = FST_PASS;
        ctrl.secOp = SEC_PASS;
        ctrl.intC = 1'b0;
        ctrl.chgCO = 1'b0;
        ctrl.chgHO = 1'b0;
        twoBeats = 1'b0;
        case (op)
            OP_OR:    ctrl.secOp = SEC_OR;
            OP_AND:   ctrl.secOp = SEC_AND;
            OP_EOR:   ctrl.secOp = SEC_EOR;
            OP_MOV:   ctrl.secOp = SEC_PASS;
            OP_TCLR1: ctrl.secOp = SEC_TCLR;
            OP_TSET1: ctrl.secOp = SEC_TSET;
            OP_XCN:   ctrl.secOp = SEC_XCN;
            OP_ASL, OP_ROL, OP_LSR, OP_ROR: begin
                ctrl.chgCO = 1'b1;
                case (op)
                    OP_ASL:  ctrl.fstOp = FST_SHL0;
                    OP_ROL:  ctrl.fstOp = FST_SHLC;
                    OP_LSR:  ctrl.fstOp = FST_SHR0;
                    default: ctrl.fstOp = FST_SHRC;
                endcase
            end
            OP_INC, OP_DEC: begin
                ctrl.fstOp = FST_ONE;
                ctrl.secOp = (op == OP_INC) ? SEC_ADD : SEC_SUB;
            end
            OP_ADC, OP_SBC: begin
                ctrl.secOp = (op == OP_ADC) ? SEC_ADC : SEC_SBC;
                ctrl.chgCO = 1'b1;
                ctrl.chgHO = 1'b1;
            end
            OP_DAA, OP_DAS: begin
                ctrl.secOp = (op == OP_DAA) ? SEC_DAA : SEC_DAS;
                ctrl.chgCO = 1'b1;
            end
            OP_ADDW, OP_SUBW: begin
                twoBeats = 1'b1;
                ctrl.chgCO = 1'b1;
                ctrl.chgHO = 1'b1;
                ctrl.intC = highBeat;
                if (op == OP_ADDW) begin
                    ctrl.secOp = highBeat ? SEC_ADC : SEC_ADD;
                end else begin
                    ctrl.secOp = highBeat ? SEC_SBC : SEC_SUB;
                end
            end
            default: ;
        endcase
    end
endmodule

`default_nettype wire

//--- verilog/spcAlu.sv
`default_nettype none

module spcAlu (
    input  logic     CLK,
    input  logic     RST_N,
    spcAluBeatIf.alu beat
);
    import spcAluPkg::*;
    import spcFlagsPkg::*;

    logic [7:0] shapedR;
    logic       shapeC;
    logic       savedC;
    logic       isAddSub;
    logic       addCi;
    logic       addMode;
    logic [7:0] addS;
    logic       addCo;
    logic       addVo;
    logic       addHo;
    logic [7:0] bcdR;
    logic       bcdCo;
    logic [7:0] result;
    logic       resC;
    logic       resH;
    logic       zeroNow;
    SpcFlags    flags;

    always_comb begin
        shapeC = beat.flagsIn.c;
        case (beat.ctrl.fstOp)
            FST_SHL0: begin
                shapeC = beat.r[7];
                shapedR = {beat.r[6:0], 1'b0};
            end
            FST_SHLC: begin
                shapeC = beat.r[7];
                shapedR = {beat.r[6:0], beat.flagsIn.c};
            end
            FST_SHR0: begin
                shapeC = beat.r[0];
                shapedR = {1'b0, beat.r[7:1]};
            end
            FST_SHRC: begin
                shapeC = beat.r[0];
                shapedR = {beat.flagsIn.c, beat.r[7:1]};
            end
            FST_ZERO: shapedR = 8'h00;
            // INC and DEC step
            FST_ONE:  shapedR = 8'h01;
            FST_INV:  shapedR = ~beat.r;
            default:  shapedR = beat.r;
        endcase
    end

    assign isAddSub = beat.ctrl.secOp inside {SEC_ADC, SEC_ADD, SEC_SBC, SEC_SUB};
    assign addMode = beat.ctrl.secOp inside {SEC_ADC, SEC_ADD};

    // Plain ADD starts with no carry, plain SUB with no borrow
    assign addCi = beat.ctrl.intC ? savedC :
                   (beat.ctrl.secOp inside {SEC_ADC, SEC_SBC}) ? beat.flagsIn.c :
                   (beat.ctrl.secOp == SEC_SUB);

    // Carry chain between the two beats of a word op
    always_ff @(posedge CLK) begin
        if (!RST_N) begin
            savedC <= 1'b0;
        end else if (beat.en && isAddSub) begin
            savedC <= addCo;
        end
    end

    spcAddSub addSub (
        .a   (beat.l),
        .b   (shapedR),
        .ci  (addCi),
        .add (addMode),
        .s   (addS),
        .co  (addCo),
        .vo  (addVo),
        .ho  (addHo)
    );

    spcBcdAdjust bcd (
        .a   (beat.l),
        .add (beat.ctrl.secOp == SEC_DAA),
        .ci  (beat.flagsIn.c),
        .hi  (beat.flagsIn.h),
        .r   (bcdR),
        .co  (bcdCo)
    );

    always_comb begin
        resC = shapeC;
        resH = 1'b0;
        case (beat.ctrl.secOp)
            SEC_OR:   result = beat.l | shapedR;
            SEC_AND:  result = beat.l & shapedR;
            SEC_EOR:  result = beat.l ^ shapedR;
            SEC_PASS: result = shapedR;
            SEC_TCLR: result = shapedR & ~beat.l;
            SEC_TSET: result = shapedR | beat.l;
            SEC_XCN:  result = {shapedR[3:0], shapedR[7:4]};
            SEC_ADC, SEC_ADD, SEC_SBC, SEC_SUB: begin
                result = addS;
                resC = addCo;
                resH = addHo;
            end
            SEC_DAA, SEC_DAS: begin
                result = bcdR;
                resC = bcdCo;
            end
            default:  result = 8'h00;
        endcase
    end

    assign zeroNow = (result == 8'h00);

    always_comb begin
        flags.s = result[7];
        // High beat of a word op keeps Z only if the low byte was zero too
        flags.z = beat.w16 ? (beat.flagsIn.z & zeroNow) : zeroNow;
        flags.v = (beat.ctrl.secOp inside {SEC_ADC, SEC_SBC}) ? addVo : beat.flagsIn.v;
        flags.c = beat.ctrl.chgCO ? resC : beat.flagsIn.c;
        flags.h = beat.ctrl.chgHO ? resH : beat.flagsIn.h;
    end

    assign beat.res = result;
    assign beat.flagsOut = flags;
endmodule

`default_nettype wire

//--- verilog/spcBcdAdjust.sv
`default_nettype none

module spcBcdAdjust (
    input  logic [7:0] a,
    input  logic       add,
    input  logic       ci,
    input  logic       hi,
    output logic [7:0] r,
    output logic       co
);
    logic       highFix;
    logic       lowFix;
    logic [7:0] step;

    always_comb begin
        if (add) begin
            highFix = ci || (a > 8'h99);
            lowFix = hi || (a[3:0] > 4'h9);
        end else begin
            highFix = !ci || (a > 8'h99);
            lowFix = !hi || (a[3:0] > 4'h9);
        end
        step = (highFix ? 8'h60 : 8'h00) + (lowFix ? 8'h06 : 8'h00);
    end

    assign r = add ? a + step : a - step;
    // Add sets carry on a high fix, subtract clears it
    assign co = add ? highFix : !highFix;
endmodule

`default_nettype wire

//--- verilog/spcAddSub.sv
`default_nettype none

module spcAddSub (
    input  logic [7:0] a,
    input  logic [7:0] b,
    input  logic       ci,
    input  logic       add,
    output logic [7:0] s,
    output logic       co,
    output logic       vo,
    output logic       ho
);
    logic [7:0] bEff;
    logic [8:0] sum;
    logic [4:0] lowSum;

    // Subtract as a + ~b + c, carry set means no borrow
    assign bEff = add ? b : ~b;
    assign sum = {1'b0, a} + {1'b0, bEff} + 9'(ci);
    assign lowSum = {1'b0, a[3:0]} + {1'b0, bEff[3:0]} + 5'(ci);

    assign s = sum[7:0];
    assign co = sum[8];
    assign ho = lowSum[4];
    assign vo = (a[7] == bEff[7]) && (sum[7] != a[7]);
endmodule

`default_nettype wire

//--- verilog/spcAluBeatIf.sv
`default_nettype none

interface spcAluBeatIf;
    logic                 en;
    spcAluPkg::SpcAluCtrl ctrl;
    logic [7:0]           l;
    logic [7:0]           r;
    logic                 w16;
    spcFlagsPkg::SpcFlags flagsIn;
    logic [7:0]           res;
    spcFlagsPkg::SpcFlags flagsOut;

    modport seq (
        output en, ctrl, l, r, w16, flagsIn,
        input  res, flagsOut
    );

    modport alu (
        input  en, ctrl, l, r, w16, flagsIn,
        output res, flagsOut
    );
endinterface

`default_nettype wire

//--- verilog/spcFlagsPkg.sv
`default_nettype none

package spcFlagsPkg;

    // Processor status bits touched by the ALU
    typedef struct packed {
        logic c;
        logic v;
        logic s;
        logic z;
        logic h;
    } SpcFlags;

endpackage

`default_nettype wire

//--- verilog/spcAluPkg.sv
`default_nettype none

package spcAluPkg;

    typedef enum logic [4:0] {
        OP_OR,
        OP_AND,
        OP_EOR,
        OP_MOV,
        OP_TCLR1,
        OP_TSET1,
        OP_XCN,
        OP_ASL,
        OP_ROL,
        OP_LSR,
        OP_ROR,
        OP_INC,
        OP_DEC,
        OP_ADC,
        OP_SBC,
        OP_DAA,
        OP_DAS,
        OP_ADDW,
        OP_SUBW
    } SpcOpcode;

    // Operand shaper, applied to the right operand
    typedef enum logic [2:0] {
        FST_SHL0 = 3'd0,
        FST_SHLC = 3'd1,
        FST_SHR0 = 3'd2,
        FST_SHRC = 3'd3,
        FST_ZERO = 3'd4,
        FST_ONE  = 3'd5,
        FST_PASS = 3'd6,
        FST_INV  = 3'd7
    } SpcFstOp;

    // Result selector; codes 8 to 11 go through the adder
    typedef enum logic [3:0] {
        SEC_OR   = 4'd0,
        SEC_AND  = 4'd1,
        SEC_EOR  = 4'd2,
        SEC_PASS = 4'd3,
        SEC_TCLR = 4'd4,
        SEC_TSET = 4'd5,
        SEC_XCN  = 4'd6,
        SEC_ADC  = 4'd8,
        SEC_ADD  = 4'd9,
        SEC_SBC  = 4'd10,
        SEC_SUB  = 4'd11,
        SEC_DAA  = 4'd12,
        SEC_DAS  = 4'd13
    } SpcSecOp;

    typedef struct packed {
        SpcFstOp fstOp;
        SpcSecOp secOp;
        logic    intC;
        logic    chgCO;
        logic    chgHO;
    } SpcAluCtrl;

endpackage

`default_nettype wire

//--- verilog/spcAlu_defs.svh
`ifndef SPC_ALU_DEFS_SVH
`define SPC_ALU_DEFS_SVH

`default_nettype none

// Request queue entries, also the client's starting request credits
`define SPC_QUEUE_DEPTH 4

// Response credits held by the sequencer after reset
`define SPC_RSP_CREDITS 2

`default_nettype wire

`endif
